// File: Makefile
# Verilator build and run of the stream reader testbench
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP      := stream_reader_tb
FILELIST := files.f
OBJ_DIR  := obj_dir

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
logic/mem_bus_pkg.sv
logic/stream_pkg.sv
logic/stream_fifo.sv
logic/node_stream_lane.sv
logic/read_issue_ctrl.sv
logic/read_return_steer.sv
logic/stream_reader_top.sv
tb/tb_clock_gen.sv
tb/stream_reader_tb.sv

// File: logic/mem_bus_pkg.sv
//******************************
// Memory read bus types
// Address, word and 64-bit beat views
//******************************
`default_nettype none

package mem_bus_pkg;

    // Bus widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned BEAT_W = 64;
    localparam int unsigned WORD_W = 32;

    // Stream words carried in one read beat
    localparam int unsigned WORDS_PER_BEAT = BEAT_W / WORD_W;

    // Byte address on the read bus
    typedef logic [ADDR_W-1:0] addr_t;

    // One stream word as seen by the array
    typedef logic [WORD_W-1:0] word_t;

    // Read beat seen whole or split in halves
    // Low half is the even word of the aligned address
    typedef union packed {
        logic [BEAT_W-1:0]                raw;
        word_t [WORDS_PER_BEAT-1:0]       word;
    } beat_t;

endpackage

`default_nettype wire

// File: logic/node_stream_lane.sv
//******************************
// One array input lane
// Address offset, pending reads and data FIFO
//******************************
`timescale 1ns/1ps
`default_nettype none

module node_stream_lane (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  stream_pkg::lane_cfg_t cfg_i,
    input  logic                  active_i,
    input  logic                  restart_i,
    input  logic                  grant_i,
    input  logic                  push_i,
    input  mem_bus_pkg::word_t    word_i,
    output stream_pkg::lane_req_t req_o,
    output logic                  end_o,
    output mem_bus_pkg::word_t    data_o,
    output logic                  valid_o,
    input  logic                  ready_i
);

    import mem_bus_pkg::*;
    import stream_pkg::*;

    logic [OFFS_W-1:0]  offset_q;
    logic [COUNT_W-1:0] pending_q;
    logic [COUNT_W-1:0] fifo_count;
    logic [COUNT_W:0]   fill;
    logic               fifo_empty;
    logic               pop;

    // Byte offset into the lane buffer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            offset_q <= '0;
        end else if (restart_i) begin
            offset_q <= '0;
        end else if (grant_i) begin
            offset_q <= offset_q + OFFS_W'(cfg_i.stride);
        end
    end

    // Reads issued but not yet returned
    // Up on grant, down on returned word, hold if both
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= '0;
        end else if (grant_i && !push_i) begin
            pending_q <= pending_q + 1'b1;
        end else if (!grant_i && push_i) begin
            pending_q <= pending_q - 1'b1;
        end
    end

    // Words stored plus words on their way
    assign fill  = {1'b0, fifo_count} + {1'b0, pending_q};
    assign end_o = (offset_q >= OFFS_W'(cfg_i.size));

    // Room is reserved at grant time so a returned word always fits
    assign req_o.req  = active_i && !end_o && (fill < (COUNT_W + 1)'(LANE_FIFO_DEPTH));
    assign req_o.addr = cfg_i.base + ADDR_W'(offset_q);

    // Array side handshake
    assign valid_o = !fifo_empty;
    assign pop     = valid_o && ready_i;

    stream_fifo #(
        .WIDTH (WORD_W),
        .DEPTH (LANE_FIFO_DEPTH)
    ) u_data_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (push_i),
        .data_i  (word_i),
        .pop_i   (pop),
        .data_o  (data_o),
        .empty_o (fifo_empty),
        .full_o  (),
        .count_o (fifo_count)
    );

endmodule

`default_nettype wire

// File: logic/read_issue_ctrl.sv
//******************************
// Read issue controller
// Run state, lane arbitration, address channel
//******************************
`timescale 1ns/1ps
`default_nettype none

module read_issue_ctrl (
    input  logic                                            clk_i,
    input  logic                                            rst_ni,
    input  logic                                            start_i,
    input  stream_pkg::lane_req_t [stream_pkg::NODE_NUM-1:0] lane_req_i,
    input  stream_pkg::node_onehot_t                        lane_end_i,
    input  logic                                            outst_empty_i,
    input  logic                                            outst_full_i,
    output stream_pkg::node_onehot_t                        grant_o,
    output logic                                            active_o,
    output logic                                            restart_o,
    output stream_pkg::trans_info_t                         trans_o,
    output logic                                            trans_push_o,
    output logic                                            done_o,
    output mem_bus_pkg::addr_t                              ar_addr_o,
    output logic                                            ar_valid_o,
    input  logic                                            ar_ready_i
);

    import mem_bus_pkg::*;
    import stream_pkg::*;

    logic                  run_q;
    logic                  run_d;
    node_onehot_t          req_vec;
    node_onehot_t          rot_prev_q;
    node_onehot_t          rot_prev_d;
    logic [2*NODE_NUM-1:0] double_req;
    logic [2*NODE_NUM-1:0] double_grant;
    logic                  ar_free;
    logic                  arb_enable;
    logic                  new_trans;
    logic                  wait_q;
    logic                  wait_d;
    addr_t                 sel_addr;
    addr_t                 addr_q;

    // Run flag clears once all lanes ended and nothing is in flight
    always_comb begin
        run_d = run_q;
        if (start_i) begin
            run_d = 1'b1;
        end else if (run_q && (&lane_end_i) && outst_empty_i) begin
            run_d = 1'b0;
        end
    end

    assign active_o  = run_q;
    assign restart_o = run_q && !run_d;
    assign done_o    = !run_q;

    // Address channel is free when idle or the current address is taken
    assign ar_free    = !wait_q || ar_ready_i;
    assign arb_enable = ar_free && !outst_full_i;

    // Round robin by doubled request minus rotated previous grant
    // Borrow stops at the first request at or left of the pointer
    always_comb begin
        for (int i = 0; i < NODE_NUM; i++) begin
            req_vec[i] = lane_req_i[i].req;
        end
        double_req   = {req_vec, req_vec};
        double_grant = double_req & ~(double_req - {{NODE_NUM{1'b0}}, rot_prev_q});
        if (arb_enable) begin
            grant_o = double_grant[NODE_NUM-1:0] | double_grant[2*NODE_NUM-1:NODE_NUM];
        end else begin
            grant_o = '0;
        end
    end

    assign new_trans = |grant_o;

    // Pointer moves one past the lane just served
    assign rot_prev_d = new_trans ? {grant_o[NODE_NUM-2:0], grant_o[NODE_NUM-1]} : rot_prev_q;

    // One-hot grant lets the OR pick the granted lane address
    always_comb begin
        sel_addr = '0;
        for (int i = 0; i < NODE_NUM; i++) begin
            if (grant_o[i]) begin
                sel_addr |= lane_req_i[i].addr;
            end
        end
    end

    // Valid is held until ready, then reloaded by a new grant or dropped
    assign wait_d = ar_free ? new_trans : wait_q;

    // Bit 2 picks the beat half
    assign trans_o      = '{node: grant_o, odd_word: sel_addr[2]};
    assign trans_push_o = new_trans;

    assign ar_valid_o = wait_q;
    assign ar_addr_o  = {addr_q[ADDR_W-1:3], 3'b000};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            run_q      <= 1'b0;
            wait_q     <= 1'b0;
            rot_prev_q <= node_onehot_t'(1);
        end else begin
            run_q      <= run_d;
            wait_q     <= wait_d;
            rot_prev_q <= rot_prev_d;
        end
    end

    // Address register
    always_ff @(posedge clk_i) begin
        if (new_trans) begin
            addr_q <= sel_addr;
        end
    end

endmodule

`default_nettype wire

// File: logic/read_return_steer.sv
//******************************
// Read return steering
// Tracks reads in flight, routes words to lanes
//******************************
`timescale 1ns/1ps
`default_nettype none

module read_return_steer (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  stream_pkg::trans_info_t  trans_i,
    input  logic                     trans_push_i,
    input  mem_bus_pkg::beat_t       r_data_i,
    input  logic                     r_valid_i,
    output logic                     r_ready_o,
    output mem_bus_pkg::word_t       word_o,
    output stream_pkg::node_onehot_t lane_push_o,
    output logic                     outst_empty_o,
    output logic                     outst_full_o
);

    import stream_pkg::*;

    // Oldest read still waiting for its beat
    trans_info_t head;

    // Lanes reserve room before issue, so returns are never refused
    assign r_ready_o = 1'b1;

    // Half of the beat named at issue time
    assign word_o = r_data_i.word[head.odd_word];

    // Beats come back in request order
    assign lane_push_o = r_valid_i ? head.node : '0;

    stream_fifo #(
        .WIDTH ($bits(trans_info_t)),
        .DEPTH (MAX_OUTSTANDING)
    ) u_tracker (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (trans_push_i),
        .data_i  (trans_i),
        .pop_i   (r_valid_i),
        .data_o  (head),
        .empty_o (outst_empty_o),
        .full_o  (outst_full_o),
        .count_o ()
    );

endmodule

`default_nettype wire

// File: logic/stream_fifo.sv
//******************************
// Synchronous FIFO with occupancy count
//******************************
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter int unsigned WIDTH = 32,
    parameter int unsigned DEPTH = 8
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       push_i,
    input  logic [WIDTH-1:0]           data_i,
    input  logic                       pop_i,
    output logic [WIDTH-1:0]           data_o,
    output logic                       empty_o,
    output logic                       full_o,
    output logic [$clog2(DEPTH+1)-1:0] count_o
);

    logic [WIDTH-1:0]           mem_q [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;
    logic                       push_ok;
    logic                       pop_ok;

    assign empty_o = (count_q == '0);
    assign full_o  = (int'(count_q) == DEPTH);
    assign count_o = count_q;
    assign data_o  = mem_q[rd_ptr_q];

    // Push at full is taken only when a pop frees the slot in the same cycle
    assign push_ok = push_i && (!full_o || pop_i);
    assign pop_ok  = pop_i && !empty_o;

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (int'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= (int'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            // Count holds on simultaneous push and pop
            if (push_ok && !pop_ok) begin
                count_q <= count_q + 1'b1;
            end else if (!push_ok && pop_ok) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/stream_pkg.sv
//******************************
// Stream reader lane and tracker types
//******************************
`default_nettype none

package stream_pkg;

    // Number of array input lanes
    localparam int unsigned NODE_NUM = 4;

    // Words held per lane data FIFO
    localparam int unsigned LANE_FIFO_DEPTH = 8;

    // Reads in flight on the bus at once
    localparam int unsigned MAX_OUTSTANDING = 10;

    // Width of lane occupancy and pending counts up to LANE_FIFO_DEPTH
    localparam int unsigned COUNT_W = 4;

    // Offset is one bit wider than size so stepping past it never wraps
    localparam int unsigned OFFS_W = 17;

    // Per lane job description
    typedef struct packed {
        mem_bus_pkg::addr_t base;
        logic [15:0]        size;
        logic [15:0]        stride;
    } lane_cfg_t;

    typedef logic [NODE_NUM-1:0] node_onehot_t;

    // What the tracker remembers about one read
    typedef struct packed {
        node_onehot_t node;
        logic         odd_word;
    } trans_info_t;

    // Lane request toward the issue side
    typedef struct packed {
        logic               req;
        mem_bus_pkg::addr_t addr;
    } lane_req_t;

endpackage

`default_nettype wire

// File: logic/stream_reader_top.sv
//******************************
// Memory to array stream reader
//******************************
`timescale 1ns/1ps
`default_nettype none

module stream_reader_top (
    input  logic                                            clk_i,
    input  logic                                            rst_ni,
    input  logic                                            start_i,
    input  stream_pkg::lane_cfg_t [stream_pkg::NODE_NUM-1:0] lane_cfg_i,
    output logic                                            done_o,
    output mem_bus_pkg::addr_t                              ar_addr_o,
    output logic                                            ar_valid_o,
    input  logic                                            ar_ready_i,
    input  mem_bus_pkg::beat_t                              r_data_i,
    input  logic                                            r_valid_i,
    output logic                                            r_ready_o,
    output mem_bus_pkg::word_t [stream_pkg::NODE_NUM-1:0]   data_o,
    output stream_pkg::node_onehot_t                        valid_o,
    input  stream_pkg::node_onehot_t                        ready_i,
    output logic                                            outst_full_o
);

    import mem_bus_pkg::*;
    import stream_pkg::*;

    lane_req_t [NODE_NUM-1:0] lane_req;
    node_onehot_t             lane_end;
    node_onehot_t             grant;
    logic                     active;
    logic                     restart;
    trans_info_t              trans;
    logic                     trans_push;
    logic                     outst_empty;
    word_t                    ret_word;
    node_onehot_t             lane_push;

    read_issue_ctrl u_issue (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .start_i       (start_i),
        .lane_req_i    (lane_req),
        .lane_end_i    (lane_end),
        .outst_empty_i (outst_empty),
        .outst_full_i  (outst_full_o),
        .grant_o       (grant),
        .active_o      (active),
        .restart_o     (restart),
        .trans_o       (trans),
        .trans_push_o  (trans_push),
        .done_o        (done_o),
        .ar_addr_o     (ar_addr_o),
        .ar_valid_o    (ar_valid_o),
        .ar_ready_i    (ar_ready_i)
    );

    read_return_steer u_steer (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .trans_i       (trans),
        .trans_push_i  (trans_push),
        .r_data_i      (r_data_i),
        .r_valid_i     (r_valid_i),
        .r_ready_o     (r_ready_o),
        .word_o        (ret_word),
        .lane_push_o   (lane_push),
        .outst_empty_o (outst_empty),
        .outst_full_o  (outst_full_o)
    );

    // Identical lanes share the returned word and a one-hot push
    for (genvar i = 0; i < NODE_NUM; i++) begin : g_lane
        node_stream_lane u_lane (
            .clk_i     (clk_i),
            .rst_ni    (rst_ni),
            .cfg_i     (lane_cfg_i[i]),
            .active_i  (active),
            .restart_i (restart),
            .grant_i   (grant[i]),
            .push_i    (lane_push[i]),
            .word_i    (ret_word),
            .req_o     (lane_req[i]),
            .end_o     (lane_end[i]),
            .data_o    (data_o[i]),
            .valid_o   (valid_o[i]),
            .ready_i   (ready_i[i])
        );
    end

endmodule

`default_nettype wire

// File: tb/stream_reader_tb.sv
//******************************
// Stream reader testbench
// Directed tests on an in-order memory model
//******************************
`timescale 1ns/1ps
`default_nettype none

module stream_reader_tb;

    import mem_bus_pkg::*;
    import stream_pkg::*;

    localparam int DRIVE_DELAY = 2;
    // Stall job is the longest and all jobs together need well under 1000 cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic                     clk;
    logic                     rst_n;
    logic                     start;
    lane_cfg_t [NODE_NUM-1:0] lane_cfg;
    logic                     done;
    addr_t                    ar_addr;
    logic                     ar_valid;
    logic                     ar_ready;
    beat_t                    r_data;
    logic                     r_valid;
    logic                     r_ready;
    word_t [NODE_NUM-1:0]     data;
    node_onehot_t             valid;
    node_onehot_t             ready;
    logic                     outst_full;

    // Memory model and scoreboard
    logic [31:0] rng_q;
    int          cycle;
    addr_t       rd_addr_q [$];
    int          rd_due_q [$];
    word_t       exp_q [NODE_NUM][$];
    int          got_cnt [NODE_NUM];
    addr_t       exp_ar_q [$];
    int          ar_cnt;
    int          full_cycles;
    logic        prev_full;
    logic        prev_ar_valid;

    // Knobs set by the tests
    logic rand_ready;
    logic rand_ar;
    int   delay_min;
    int   delay_span;

    tb_clock_gen u_clk (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    stream_reader_top dut0 (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .start_i      (start),
        .lane_cfg_i   (lane_cfg),
        .done_o       (done),
        .ar_addr_o    (ar_addr),
        .ar_valid_o   (ar_valid),
        .ar_ready_i   (ar_ready),
        .r_data_i     (r_data),
        .r_valid_i    (r_valid),
        .r_ready_o    (r_ready),
        .data_o       (data),
        .valid_o      (valid),
        .ready_i      (ready),
        .outst_full_o (outst_full)
    );

    function automatic logic [31:0] next_rand();
        rng_q ^= rng_q << 13;
        rng_q ^= rng_q >> 17;
        rng_q ^= rng_q << 5;
        return rng_q;
    endfunction

    // Memory content
    function automatic word_t mem_word(input addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic beat_t beat_at(input addr_t a);
        beat_t b;
        addr_t aligned;
        aligned   = a & ~addr_t'(32'h7);
        b.word[0] = mem_word(aligned);
        b.word[1] = mem_word(aligned + 32'd4);
        return b;
    endfunction

    function automatic lane_cfg_t make_cfg(input addr_t base, input int size, input int stride);
        lane_cfg_t c;
        c.base   = base;
        c.size   = 16'(size);
        c.stride = 16'(stride);
        return c;
    endfunction

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                      $time, name, got, exp));
        end
    endtask

    // Observe half a cycle before the coming edge where values are settled
    task automatic sample_cycle();
        int delay;
        cycle++;
        if (cycle >= TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("Timeout, job still running after %0d cycles", cycle));
        end else if (rst_n) begin
            check_bit("r_ready_o", r_ready, 1'b1);
            // Tracker holds accepted reads plus the one waiting on the address channel
            check_bit("outst_full_o", outst_full,
                      (rd_addr_q.size() + int'(ar_valid)) == int'(MAX_OUTSTANDING));
            // Full tracker blocks any new address
            if (prev_full && !prev_ar_valid) begin
                check_bit("ar_valid_o", ar_valid, 1'b0);
            end
            if (outst_full) begin
                full_cycles++;
            end
            // Beat consumed at the coming edge
            if (r_valid) begin
                void'(rd_addr_q.pop_front());
                void'(rd_due_q.pop_front());
            end
            if (ar_valid && ar_ready) begin
                check_bit("ar_addr_o[2:0] zero", ar_addr[2:0] == 3'b000, 1'b1);
                if (ar_cnt < exp_ar_q.size()) begin
                    check_addr("ar_addr_o", ar_addr, exp_ar_q[ar_cnt]);
                end
                ar_cnt++;
                delay = delay_min + int'(next_rand() % 32'(delay_span));
                rd_addr_q.push_back(ar_addr);
                rd_due_q.push_back(cycle + delay);
            end
            for (int i = 0; i < NODE_NUM; i++) begin
                if (valid[i] && ready[i]) begin
                    if (got_cnt[i] >= exp_q[i].size()) begin
                        stop_with_error($sformatf("Lane %0d delivered a word past its job", i));
                    end else begin
                        check_word($sformatf("data_o[%0d]", i), data[i], exp_q[i][got_cnt[i]]);
                        got_cnt[i]++;
                    end
                end
            end
            prev_full     = outst_full;
            prev_ar_valid = ar_valid;
        end
    endtask

    // Beats return in order once due
    task automatic drive_cycle();
        ar_ready = rand_ar ? ((next_rand() % 32'd3) != 32'd0) : 1'b1;
        ready    = rand_ready ? node_onehot_t'(next_rand()) : '1;
        if (rd_addr_q.size() > 0 && rd_due_q[0] <= cycle) begin
            r_valid = 1'b1;
            r_data  = beat_at(rd_addr_q[0]);
        end else begin
            r_valid = 1'b0;
            r_data  = '0;
        end
    endtask

    initial begin : bus_model
        rng_q         = 32'h223f_e2a5;
        cycle         = 0;
        ar_cnt        = 0;
        full_cycles   = 0;
        prev_full     = 1'b0;
        prev_ar_valid = 1'b0;
        ar_ready      = 1'b0;
        r_valid       = 1'b0;
        r_data        = '0;
        ready         = '0;
        for (int i = 0; i < NODE_NUM; i++) begin
            got_cnt[i] = 0;
        end
        forever begin
            @(negedge clk);
            sample_cycle();
            @(posedge clk);
            #(DRIVE_DELAY);
            drive_cycle();
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    // Words at base plus every stride step below size
    task automatic expect_lane(input int lane, input lane_cfg_t c);
        for (int off = 0; off < int'(c.size); off += int'(c.stride)) begin
            exp_q[lane].push_back(mem_word(c.base + addr_t'(off)));
        end
    endtask

    function automatic logic lanes_drained();
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < NODE_NUM; i++) begin
            if (got_cnt[i] != exp_q[i].size()) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    task automatic run_job(input lane_cfg_t [NODE_NUM-1:0] cfg);
        for (int i = 0; i < NODE_NUM; i++) begin
            expect_lane(i, cfg[i]);
        end
        lane_cfg = cfg;
        start    = 1'b1;
        next_cycle();
        start    = 1'b0;
        check_bit("done_o after start", done, 1'b0);
        while (!done) begin
            next_cycle();
        end
        // Busy ends only once the last beat is back
        check_bit("all reads returned at done_o", rd_addr_q.size() == 0, 1'b1);
        while (!lanes_drained()) begin
            next_cycle();
        end
    endtask

    task automatic test_reset_state();
        check_bit("done_o", done, 1'b1);
        check_bit("ar_valid_o", ar_valid, 1'b0);
        check_bit("outst_full_o", outst_full, 1'b0);
        for (int i = 0; i < NODE_NUM; i++) begin
            check_bit($sformatf("valid_o[%0d]", i), valid[i], 1'b0);
        end
    endtask

    // Single lane from an odd word with reads going out in word order
    task automatic test_contiguous();
        lane_cfg_t [NODE_NUM-1:0] cfg;
        addr_t                    a;
        for (int i = 0; i < NODE_NUM; i++) begin
            cfg[i] = make_cfg(32'h0000_0000, 0, 4);
        end
        cfg[0] = make_cfg(32'h0000_0104, 32, 4);
        for (int k = 0; k < 8; k++) begin
            a = cfg[0].base + addr_t'(4 * k);
            exp_ar_q.push_back(a & ~addr_t'(32'h7));
        end
        run_job(cfg);
    endtask

    task automatic test_strided();
        lane_cfg_t [NODE_NUM-1:0] cfg;
        cfg[0] = make_cfg(32'h0000_1000, 24, 4);
        cfg[1] = make_cfg(32'h0000_2004, 48, 8);
        cfg[2] = make_cfg(32'h0000_3000, 60, 12);
        cfg[3] = make_cfg(32'h0000_4004, 100, 20);
        run_job(cfg);
    endtask

    task automatic test_backpressure();
        lane_cfg_t [NODE_NUM-1:0] cfg;
        cfg[0] = make_cfg(32'h0000_8000, 64, 4);
        cfg[1] = make_cfg(32'h0000_9004, 96, 8);
        cfg[2] = make_cfg(32'h0000_a00c, 300, 28);
        cfg[3] = make_cfg(32'h0000_b000, 160, 16);
        rand_ready = 1'b1;
        rand_ar    = 1'b1;
        run_job(cfg);
        rand_ready = 1'b0;
        rand_ar    = 1'b0;
    endtask

    // Same job twice so offsets must start over
    task automatic test_restart();
        lane_cfg_t [NODE_NUM-1:0] cfg;
        cfg[0] = make_cfg(32'h0002_0000, 40, 8);
        cfg[1] = make_cfg(32'h0002_1004, 20, 4);
        cfg[2] = make_cfg(32'h0002_2000, 0, 4);
        cfg[3] = make_cfg(32'h0002_3000, 72, 24);
        run_job(cfg);
        run_job(cfg);
    endtask

    // Slow memory with every lane busy fills the tracker
    task automatic test_stall();
        lane_cfg_t [NODE_NUM-1:0] cfg;
        int                       full_before;
        for (int i = 0; i < NODE_NUM; i++) begin
            cfg[i] = make_cfg(addr_t'(32'h0001_0000 * (i + 1)), 64, 4);
        end
        full_before = full_cycles;
        delay_min   = 40;
        delay_span  = 8;
        run_job(cfg);
        check_bit("outst_full_o seen high", full_cycles > full_before, 1'b1);
        delay_min  = 1;
        delay_span = 4;
    endtask

    initial begin : run_tests
        start      = 1'b0;
        lane_cfg   = '0;
        rand_ready = 1'b0;
        rand_ar    = 1'b0;
        delay_min  = 1;
        delay_span = 4;
        wait (rst_n === 1'b1);
        next_cycle();
        test_reset_state();
        test_contiguous();
        test_strided();
        test_backpressure();
        test_restart();
        test_stall();
        repeat (4) next_cycle();
        if (valid != '0 || ar_valid) begin
            stop_with_error("Words or reads were left over after the last test");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
//******************************
// Testbench clock and reset
//******************************
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    // 40 ns period
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Released just after an edge like every other input
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 rst_no = 1'b1;
    end

endmodule

`default_nettype wire
